/* files.f */
source/dft_pkg.sv
source/test_data_reg.sv
source/test_ctrl_block.sv
source/block_scan_chain.sv
source/dft_subsys_top.sv
verif/tb_clk_gen.sv
verif/tb_dft_subsys.sv

/* Bender.yml */
package:
  name: dft_subsys

sources:
  - files:
      - source/dft_pkg.sv
      - source/test_data_reg.sv
      - source/test_ctrl_block.sv
      - source/block_scan_chain.sv
      - source/dft_subsys_top.sv
  - target: test
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_dft_subsys.sv

/* verif/tb_dft_subsys.sv */
`timescale 1ns/1ps

module tb_dft_subsys
  import dft_pkg::*;
;

  localparam int CHAIN_LEN   = 8;
  localparam int RST_CYCLES  = 3;
  localparam int LOAD_LEN    = TDR_W + 2;  // Shifts, update, TCB register
  localparam int CTRL_ROUNDS = 4;
  localparam int FUNC_ROUNDS = 4;
  localparam int FUNC_CYC    = 6;
  localparam int TIMEOUT_CYCLES = RST_CYCLES + 1 + (TDR_W + 1) + CTRL_ROUNDS * LOAD_LEN
                                + FUNC_ROUNDS * (LOAD_LEN + FUNC_CYC)
                                + 3 * LOAD_LEN + 2 * CHAIN_LEN + 5 + (LOAD_LEN + 1) + 40;

  typedef struct packed {
    logic       scan_mode_n;
    logic       scan_rst_n;
    logic       scan_shift_n;
    logic       pipe_scanen;
    logic [1:0] dftcore2dll;
  } strobes_t;

  localparam strobes_t RESET_STROBES = 6'b111000;

  logic                            clk;
  logic                            rst_n;
  tdr_op_e                         tdr_op;
  logic                            tdi;
  logic [DLL_STATUS_W-1:0]         dll_status;
  logic [NUM_BLOCKS-1:0]           scan_in;
  logic [NUM_BLOCKS*CHAIN_LEN-1:0] func_d;
  logic                            tdo;
  logic [NUM_BLOCKS-1:0]           scan_out;
  logic [NUM_BLOCKS*CHAIN_LEN-1:0] func_q;
  strobes_t                        dut_strobes;

  // Reference model state
  logic [TDR_W-1:0]           m_shift;
  static_common_t             m_static;
  tcm_ctrl_t [NUM_BLOCKS-1:0] m_tcm;
  strobes_t                   m_strobes;
  logic [CHAIN_LEN-1:0]       m_chain [NUM_BLOCKS];

  logic [15:0]           lfsr_q;
  int                    tdo_errs, strobe_errs, func_errs, scan_errs, cycle_cnt;
  static_common_t        cfg;
  logic [TDR_W-1:0]      cap_bits;
  logic [NUM_BLOCKS-1:0] exp_so;
  logic [NUM_BLOCKS-1:0] sent [$];

  tb_clk_gen #(.PERIOD_NS(40.0), .RST_CYCLES(RST_CYCLES)) u_clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  dft_subsys_top #(.CHAIN_LEN(CHAIN_LEN)) u_dut (
    .i_tck (clk), .i_rst_n (rst_n), .i_tdr_op (tdr_op), .i_tdi (tdi),
    .i_dll_status (dll_status), .i_scan_in (scan_in), .i_func_d (func_d),
    .o_tdo (tdo), .o_scan_out (scan_out), .o_func_q (func_q),
    .o_scan_mode_n (dut_strobes.scan_mode_n), .o_scan_rst_n (dut_strobes.scan_rst_n),
    .o_scan_shift_n (dut_strobes.scan_shift_n),
    .o_global_pipe_scanen (dut_strobes.pipe_scanen), .o_dftcore2dll (dut_strobes.dftcore2dll)
  );

  // ********************
  // Random source
  // ********************

  function automatic logic lfsr_bit();
    logic out;
    out = lfsr_q[0];
    lfsr_q = lfsr_q >> 1;
    if (out) lfsr_q = lfsr_q ^ 16'hB400;
    return out;
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) v[i] = lfsr_bit();
    return v;
  endfunction

  function automatic static_common_t rand_static();
    logic [TDR_W-1:0] raw;
    raw = TDR_W'(rand_bits(TDR_W));
    return static_common_t'(raw);
  endfunction

  // ********************
  // Reference model
  // ********************

  function automatic strobes_t decode_strobes(input static_common_t s);
    strobes_t d;
    d.scan_mode_n  = ~s.scan_mode;
    d.scan_rst_n   = ~s.scan_reset;
    d.scan_shift_n = ~(s.scan_enable & s.scan_mode);  // No shift outside scan mode
    d.pipe_scanen  = s.loes_mode;
    d.dftcore2dll  = s.dftcore2dll;
    return d;
  endfunction

  // Later stages first, so each one sees last cycle's upstream value
  task automatic model_step();
    logic [CHAIN_LEN-1:0] fd;
    for (int k = 0; k < NUM_BLOCKS; k++) begin
      fd = func_d[k*CHAIN_LEN +: CHAIN_LEN];
      if (m_tcm[k].scan_mode) begin
        if (m_tcm[k].scan_enable) m_chain[k] = {m_chain[k][CHAIN_LEN-2:0], scan_in[k]};
        else if (!m_strobes.scan_rst_n) m_chain[k] = '0;
        else if (m_tcm[k].mode == TCM_CAPTURE) m_chain[k] = fd;
      end else begin
        case (m_tcm[k].mode)
          TCM_FUNC, TCM_CAPTURE: m_chain[k] = fd;
          TCM_OFF:               m_chain[k] = '0;
          default:               ;  // Hold
        endcase
      end
    end
    for (int k = 0; k < NUM_BLOCKS; k++) begin
      m_tcm[k].scan_mode   = m_static.scan_mode;
      m_tcm[k].scan_enable = m_static.scan_enable & m_static.scan_mode;
      m_tcm[k].mode        = m_static.tcm_mode[k];
    end
    m_strobes = decode_strobes(m_static);
    if (tdr_op == TDR_UPDATE) m_static = static_common_t'(m_shift);
    if (tdr_op == TDR_CAPTURE) m_shift = TDR_W'(dll_status);
    else if (tdr_op == TDR_SHIFT) m_shift = {tdi, m_shift[TDR_W-1:1]};
  endtask

  // ********************
  // Compare tasks
  // ********************

  task automatic check_tdo(input logic got, input logic exp);
    if (got !== exp) begin
      tdo_errs++;
      $display("Error: o_tdo got 0x%h expected 0x%h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_strobes(input strobes_t got, input strobes_t exp);
    if (got !== exp) begin
      strobe_errs++;
      $display("Error: {o_scan_mode_n,o_scan_rst_n,o_scan_shift_n,o_global_pipe_scanen,%s",
               "o_dftcore2dll}");
      $display("Error:   got 0x%h expected 0x%h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_func_q(input int k, input logic [CHAIN_LEN-1:0] got,
                              input logic [CHAIN_LEN-1:0] exp);
    if (got !== exp) begin
      func_errs++;
      $display("Error: o_func_q block %0d got 0x%h expected 0x%h at %0t", k, got, exp, $time);
    end
  endtask

  task automatic check_scan_out(input logic [NUM_BLOCKS-1:0] got,
                                input logic [NUM_BLOCKS-1:0] exp);
    if (got !== exp) begin
      scan_errs++;
      $display("Error: o_scan_out got 0x%h expected 0x%h at %0t", got, exp, $time);
    end
  endtask

  task automatic check_all();
    logic [NUM_BLOCKS-1:0] so;
    check_tdo(tdo, m_shift[0]);
    check_strobes(dut_strobes, m_strobes);
    for (int k = 0; k < NUM_BLOCKS; k++) begin
      check_func_q(k, func_q[k*CHAIN_LEN +: CHAIN_LEN], m_chain[k]);
      so[k] = m_chain[k][CHAIN_LEN-1];
    end
    check_scan_out(scan_out, so);
  endtask

  // Model follows the rising edge and outputs are read on the falling one
  task automatic tick();
    @(posedge clk);
    model_step();
    @(negedge clk);
    check_all();
  endtask

  // Shifts the word in LSB first and returns once the TCB holds it
  task automatic load_static(input static_common_t v);
    logic [TDR_W-1:0] bits;
    bits = v;
    for (int i = 0; i < TDR_W; i++) begin
      tdr_op = TDR_SHIFT;
      tdi    = bits[i];
      tick();
    end
    tdr_op = TDR_UPDATE;
    tick();
    tdr_op = TDR_IDLE;
    tick();
  endtask

  // ********************
  // Timeout
  // ********************

  initial begin
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("Simulation finished: FAIL");
    $finish;
  end

  // ********************
  // Tests
  // ********************

  initial begin
    lfsr_q      = 16'd83;
    tdo_errs    = 0;
    strobe_errs = 0;
    func_errs   = 0;
    scan_errs   = 0;
    tdr_op      = TDR_IDLE;
    tdi         = 1'b0;
    dll_status  = '0;
    scan_in     = '0;
    func_d      = '0;
    m_shift     = '0;
    m_static    = '0;
    m_tcm       = '0;
    m_strobes   = RESET_STROBES;
    for (int k = 0; k < NUM_BLOCKS; k++) m_chain[k] = '0;
    wait (rst_n === 1'b1);

    // Reset values
    check_strobes(dut_strobes, RESET_STROBES);
    for (int k = 0; k < NUM_BLOCKS; k++) check_func_q(k, func_q[k*CHAIN_LEN +: CHAIN_LEN], '0);
    check_scan_out(scan_out, '0);

    // DLL status leaves LSB first with zero padding
    dll_status = DLL_STATUS_W'(rand_bits(DLL_STATUS_W));
    tdr_op = TDR_CAPTURE;
    tick();
    cap_bits = {{(TDR_W-DLL_STATUS_W){1'b0}}, dll_status};
    for (int j = 0; j < TDR_W; j++) begin
      check_tdo(tdo, cap_bits[j]);
      tdr_op = TDR_SHIFT;
      tdi = lfsr_bit();
      tick();
    end
    tdr_op = TDR_IDLE;

    for (int r = 0; r < CTRL_ROUNDS; r++) begin
      cfg = rand_static();
      load_static(cfg);
      check_strobes(dut_strobes, decode_strobes(cfg));
    end

    // Functional modes with scan off
    for (int r = 0; r < FUNC_ROUNDS; r++) begin
      cfg = rand_static();
      cfg.scan_mode = 1'b0;
      load_static(cfg);
      for (int c = 0; c < FUNC_CYC; c++) begin
        func_d = (NUM_BLOCKS*CHAIN_LEN)'(rand_bits(NUM_BLOCKS*CHAIN_LEN));
        tick();
      end
    end

    // Each scan pin bit shows up CHAIN_LEN edges later
    cfg = rand_static();
    cfg.scan_mode   = 1'b1;
    cfg.scan_enable = 1'b1;
    cfg.scan_reset  = 1'b0;
    load_static(cfg);
    for (int n = 0; n < CHAIN_LEN + 4; n++) begin
      scan_in = NUM_BLOCKS'(rand_bits(NUM_BLOCKS));
      sent.push_back(scan_in);
      tick();
      if (sent.size() == CHAIN_LEN) check_scan_out(scan_out, sent.pop_front());
    end

    // Capture then unload while func_d stays put
    cfg.scan_enable = 1'b0;
    for (int k = 0; k < NUM_BLOCKS; k++) cfg.tcm_mode[k] = TCM_CAPTURE;
    load_static(cfg);
    func_d = (NUM_BLOCKS*CHAIN_LEN)'(rand_bits(NUM_BLOCKS*CHAIN_LEN));
    tick();
    cfg.scan_enable = 1'b1;
    load_static(cfg);
    scan_in = '1;  // Chains refill with ones
    for (int j = 0; j < CHAIN_LEN; j++) begin
      for (int k = 0; k < NUM_BLOCKS; k++) exp_so[k] = func_d[k*CHAIN_LEN + CHAIN_LEN-1-j];
      check_scan_out(scan_out, exp_so);
      tick();
    end

    // Scan reset clears every chain
    cfg = rand_static();
    cfg.scan_mode   = 1'b1;
    cfg.scan_reset  = 1'b1;
    cfg.scan_enable = 1'b0;
    load_static(cfg);
    tick();
    for (int k = 0; k < NUM_BLOCKS; k++) check_func_q(k, func_q[k*CHAIN_LEN +: CHAIN_LEN], '0);

    $display("Errors: o_tdo %0d, strobes %0d, o_func_q %0d, o_scan_out %0d, total %0d",
             tdo_errs, strobe_errs, func_errs, scan_errs,
             tdo_errs + strobe_errs + func_errs + scan_errs);
    if (tdo_errs + strobe_errs + func_errs + scan_errs == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter real PERIOD_NS  = 40.0,
  parameter int  RST_CYCLES = 3
) (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2.0) o_clk = ~o_clk;
  end

  // Release lands on a falling edge, clear of the sampling edge
  initial begin
    o_rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

/* source/dft_subsys_top.sv */
`timescale 1ns/1ps

module dft_subsys_top
  import dft_pkg::*;
#(
  parameter int CHAIN_LEN = 8
) (
  input  logic                            i_tck,
  input  logic                            i_rst_n,
  input  tdr_op_e                         i_tdr_op,
  input  logic                            i_tdi,
  input  logic [DLL_STATUS_W-1:0]         i_dll_status,
  input  logic [NUM_BLOCKS-1:0]           i_scan_in,
  input  logic [NUM_BLOCKS*CHAIN_LEN-1:0] i_func_d,      // Block k at k*CHAIN_LEN
  output logic                            o_tdo,
  output logic [NUM_BLOCKS-1:0]           o_scan_out,
  output logic [NUM_BLOCKS*CHAIN_LEN-1:0] o_func_q,
  output logic                            o_scan_mode_n,
  output logic                            o_scan_rst_n,
  output logic                            o_scan_shift_n,
  output logic                            o_global_pipe_scanen,
  output logic [1:0]                      o_dftcore2dll
);

  static_common_t                 static_ctrl;
  tcm_ctrl_t [NUM_BLOCKS-1:0]     tcm_ctrl;
  logic      [NUM_BLOCKS-1:0]     chain_in;
  logic      [NUM_BLOCKS-1:0]     chain_out;

  test_data_reg u_tdr (
    .i_tck        (i_tck),
    .i_rst_n      (i_rst_n),
    .i_tdr_op     (i_tdr_op),
    .i_tdi        (i_tdi),
    .i_dll_status (i_dll_status),
    .o_tdo        (o_tdo),
    .o_static     (static_ctrl)
  );

  test_ctrl_block u_tcb (
    .i_tck                (i_tck),
    .i_rst_n              (i_rst_n),
    .i_static             (static_ctrl),
    .i_scan_in            (i_scan_in),
    .i_chain_out          (chain_out),
    .o_tcm_ctrl           (tcm_ctrl),
    .o_chain_in           (chain_in),
    .o_scan_out           (o_scan_out),
    .o_scan_mode_n        (o_scan_mode_n),
    .o_scan_rst_n         (o_scan_rst_n),
    .o_scan_shift_n       (o_scan_shift_n),
    .o_global_pipe_scanen (o_global_pipe_scanen),
    .o_dftcore2dll        (o_dftcore2dll)
  );

  // One chain per internal block, all sharing the global scan reset
  for (genvar k = 0; k < NUM_BLOCKS; k++) begin : g_chain
    block_scan_chain #(
      .CHAIN_LEN (CHAIN_LEN)
    ) u_chain (
      .i_tck        (i_tck),
      .i_rst_n      (i_rst_n),
      .i_tcm_ctrl   (tcm_ctrl[k]),
      .i_scan_rst_n (o_scan_rst_n),
      .i_func_d     (i_func_d[k*CHAIN_LEN +: CHAIN_LEN]),
      .i_scan_in    (chain_in[k]),
      .o_func_q     (o_func_q[k*CHAIN_LEN +: CHAIN_LEN]),
      .o_scan_out   (chain_out[k])
    );
  end

endmodule

/* source/block_scan_chain.sv */
`timescale 1ns/1ps

module block_scan_chain
  import dft_pkg::*;
#(
  parameter int CHAIN_LEN = 8
) (
  input  logic                 i_tck,
  input  logic                 i_rst_n,
  input  tcm_ctrl_t            i_tcm_ctrl,    // Local test control from the TCB
  input  logic                 i_scan_rst_n,  // Global scan reset strobe
  input  logic [CHAIN_LEN-1:0] i_func_d,      // Functional next state
  input  logic                 i_scan_in,
  output logic [CHAIN_LEN-1:0] o_func_q,
  output logic                 o_scan_out
);

  logic [CHAIN_LEN-1:0] chain_q;
  logic [CHAIN_LEN-1:0] chain_d;

  // Scan mode priority is shift, then scan reset, then capture
  always_comb begin
    chain_d = chain_q;
    if (i_tcm_ctrl.scan_mode) begin
      if (i_tcm_ctrl.scan_enable) begin
        chain_d = {chain_q[CHAIN_LEN-2:0], i_scan_in};  // Index i moves to i+1
      end else if (!i_scan_rst_n) begin
        chain_d = '0;
      end else if (i_tcm_ctrl.mode == TCM_CAPTURE) begin
        chain_d = i_func_d;
      end
    end else begin
      case (i_tcm_ctrl.mode)
        TCM_FUNC, TCM_CAPTURE: chain_d = i_func_d;
        TCM_OFF:               chain_d = '0;
        default:               chain_d = chain_q;  // Hold
      endcase
    end
  end

  always_ff @(posedge i_tck or negedge i_rst_n) begin
    if (!i_rst_n) begin
      chain_q <= '0;
    end else begin
      chain_q <= chain_d;
    end
  end

  assign o_func_q   = chain_q;
  assign o_scan_out = chain_q[CHAIN_LEN-1];

  // ********************
  // Checks
  // ********************

  // Shift enable only ever arrives together with scan mode
  a_no_shift_func: assert property (
    @(posedge i_tck) disable iff (!i_rst_n)
    i_tcm_ctrl.scan_enable |-> i_tcm_ctrl.scan_mode
  ) else $error("Chain told to shift outside scan mode");

endmodule

/* source/test_ctrl_block.sv */
`timescale 1ns/1ps

module test_ctrl_block
  import dft_pkg::*;
(
  input  logic                             i_tck,
  input  logic                             i_rst_n,
  input  static_common_t                   i_static,      // From the TDR update stage
  input  logic           [NUM_BLOCKS-1:0]  i_scan_in,     // Top-level scan pins
  input  logic           [NUM_BLOCKS-1:0]  i_chain_out,   // Last flop of each chain
  output tcm_ctrl_t      [NUM_BLOCKS-1:0]  o_tcm_ctrl,    // One TCM word per block
  output logic           [NUM_BLOCKS-1:0]  o_chain_in,    // Serial input of each chain
  output logic           [NUM_BLOCKS-1:0]  o_scan_out,    // Top-level scan out pins
  output logic                             o_scan_mode_n,
  output logic                             o_scan_rst_n,
  output logic                             o_scan_shift_n,
  output logic                             o_global_pipe_scanen,
  output logic           [1:0]             o_dftcore2dll
);

  logic                            shift_en;
  tcm_ctrl_t [NUM_BLOCKS-1:0]      tcm_ctrl_d;

  // Shift is meaningless outside scan mode
  assign shift_en = i_static.scan_enable & i_static.scan_mode;

  // ********************
  // TCM word decode
  // ********************

  always_comb begin
    for (int k = 0; k < NUM_BLOCKS; k++) begin
      tcm_ctrl_d[k].scan_mode   = i_static.scan_mode;
      tcm_ctrl_d[k].scan_enable = shift_en;
      tcm_ctrl_d[k].mode        = i_static.tcm_mode[k];
    end
  end

  always_ff @(posedge i_tck or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_tcm_ctrl <= '0;  // Functional mode with scan off
    end else begin
      o_tcm_ctrl <= tcm_ctrl_d;
    end
  end

  // ********************
  // Global strobes
  // ********************

  always_ff @(posedge i_tck or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_scan_mode_n        <= 1'b1;
      o_scan_rst_n         <= 1'b1;
      o_scan_shift_n       <= 1'b1;
      o_global_pipe_scanen <= 1'b0;
      o_dftcore2dll        <= 2'b00;
    end else begin
      o_scan_mode_n        <= ~i_static.scan_mode;
      o_scan_rst_n         <= ~i_static.scan_reset;
      o_scan_shift_n       <= ~shift_en;
      o_global_pipe_scanen <= i_static.loes_mode;
      o_dftcore2dll        <= i_static.dftcore2dll;  // Straight to the DLL
    end
  end

  // Scan data path has no flops of its own
  assign o_chain_in = i_scan_in;
  assign o_scan_out = i_chain_out;

  // ********************
  // Checks
  // ********************

  a_shift_in_scan_mode: assert property (
    @(posedge i_tck) disable iff (!i_rst_n)
    !o_scan_shift_n |-> !o_scan_mode_n
  ) else $error("Scan shift strobe active outside scan mode");

  for (genvar k = 0; k < NUM_BLOCKS; k++) begin : g_tcm_chk
    a_tcm_enable: assert property (
      @(posedge i_tck) disable iff (!i_rst_n)
      o_tcm_ctrl[k].scan_enable |-> o_tcm_ctrl[k].scan_mode
    ) else $error("TCM word %0d enables shift outside scan mode", k);
  end

endmodule

/* source/test_data_reg.sv */
`timescale 1ns/1ps

module test_data_reg
  import dft_pkg::*;
(
  input  logic                    i_tck,         // Test clock
  input  logic                    i_rst_n,
  input  tdr_op_e                 i_tdr_op,      // Operation from the TAP side
  input  logic                    i_tdi,         // Serial data in
  input  logic [DLL_STATUS_W-1:0] i_dll_status,  // Loaded on capture
  output logic                    o_tdo,         // Serial data out
  output static_common_t          o_static       // Update stage driving the controls
);

  logic [TDR_W-1:0] shift_q;
  logic [TDR_W-1:0] capture_val;
  logic [TDR_W-1:0] shift_d;
  logic             update_en;

  // Status sits in the low bits so it leaves first
  assign capture_val = {{(TDR_W-DLL_STATUS_W){1'b0}}, i_dll_status};

  assign update_en = (i_tdr_op == TDR_UPDATE);

  // ********************
  // Shift stage
  // ********************

  always_comb begin
    case (i_tdr_op)
      TDR_CAPTURE: begin
        shift_d = capture_val;
      end
      TDR_SHIFT: begin
        shift_d = {i_tdi, shift_q[TDR_W-1:1]};  // Toward LSB
      end
      default: begin
        shift_d = shift_q;  // Idle and update leave it alone
      end
    endcase
  end

  always_ff @(posedge i_tck or negedge i_rst_n) begin
    if (!i_rst_n) begin
      shift_q <= '0;
    end else begin
      shift_q <= shift_d;
    end
  end

  assign o_tdo = shift_q[0];

  // ********************
  // Update stage
  // ********************

  // Only this stage reaches the TCB, so shifting leaves the controls steady
  always_ff @(posedge i_tck or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_static <= '0;
    end else if (update_en) begin
      o_static <= static_common_t'(shift_q);
    end
  end

  // ********************
  // Checks
  // ********************

  a_tdr_op_known: assert property (
    @(posedge i_tck) disable iff (!i_rst_n)
    !$isunknown(i_tdr_op)
  ) else $error("TDR opcode unknown");

endmodule

/* source/dft_pkg.sv */
package dft_pkg;

  // ********************
  // Sizes
  // ********************

  localparam int NUM_BLOCKS   = 4;   // Block chains behind the wrapper TCB
  localparam int DLL_STATUS_W = 13;  // DLL status word seen on capture

  // ********************
  // Enums
  // ********************

  // Operation applied to the test data register this cycle
  typedef enum logic [1:0] {
    TDR_IDLE    = 2'd0,
    TDR_CAPTURE = 2'd1,
    TDR_SHIFT   = 2'd2,
    TDR_UPDATE  = 2'd3
  } tdr_op_e;

  // Per-block register behavior
  typedef enum logic [1:0] {
    TCM_FUNC    = 2'd0,  // Functional load
    TCM_CAPTURE = 2'd1,  // Capture in scan mode
    TCM_HOLD    = 2'd2,
    TCM_OFF     = 2'd3   // Block parked at zero
  } tcm_mode_e;

  // ********************
  // Control words
  // ********************

  typedef struct packed {
    logic                        scan_mode;
    logic                        scan_reset;
    logic                        scan_enable;
    logic                        loes_mode;    // Launch-off-extra-shift pipe enable
    logic [1:0]                  dftcore2dll;
    tcm_mode_e [NUM_BLOCKS-1:0]  tcm_mode;     // One mode per block chain
  } static_common_t;

  localparam int TDR_W = $bits(static_common_t);

  typedef struct packed {
    logic      scan_mode;
    logic      scan_enable;  // Already qualified by scan_mode
    tcm_mode_e mode;
  } tcm_ctrl_t;

endpackage
